/* src/sort_defs.svh */
`ifndef SORT_DEFS_SVH
`define SORT_DEFS_SVH

// Keys in one set
`define SORT_LANES 16

// Key width in bits
`define SORT_KEY_W 8

// Lane number and rank width, log2 of the lane count
`define SORT_IDX_W 4

`endif

/* src/sort_pkg.sv */
`include "sort_defs.svh"

package sort_pkg;

    //////////////////////////////
    // Scalar types
    //////////////////////////////

    // One unsigned key
    typedef logic [`SORT_KEY_W-1:0] key_t;

    // Lane number or rank
    typedef logic [`SORT_IDX_W-1:0] idx_t;

    //////////////////////////////
    // Per set types
    //////////////////////////////

    // One key per lane, lane 0 in element 0
    typedef key_t [`SORT_LANES-1:0] key_vec_t;

    // One rank or source lane per element
    typedef idx_t [`SORT_LANES-1:0] idx_vec_t;

    // Row i, bit j set when key j comes before key i
    typedef logic [`SORT_LANES-1:0][`SORT_LANES-1:0] prec_mat_t;

endpackage

/* src/compare_matrix.sv */
`timescale 1ns/100ps
`include "sort_defs.svh"

module compare_matrix
    import sort_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  key_vec_t  in_keys,
    output logic      cmp_valid,
    output key_vec_t  cmp_keys,
    output prec_mat_t cmp_prec
);

    prec_mat_t prec_next;

    //////////////////////////////
    // Pairwise precedence
    //////////////////////////////

    // Key j comes before key i if smaller, or if equal and from a lower lane
    always_comb
    begin
        for (int i = 0; i < `SORT_LANES; i++)
        begin
            for (int j = 0; j < `SORT_LANES; j++)
            begin
                if (in_keys[j] < in_keys[i])
                begin
                    prec_next[i][j] = 1'b1;
                end
                else if ((in_keys[j] == in_keys[i]) && (j < i))
                begin
                    prec_next[i][j] = 1'b1;
                end
                else
                begin
                    prec_next[i][j] = 1'b0;
                end
            end
        end
    end

    //////////////////////////////
    // Stage registers
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cmp_valid <= 1'b0;
        end
        else
        begin
            cmp_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        cmp_keys <= in_keys;
        cmp_prec <= prec_next;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Tie break must order every pair one way only, so that ranks stay unique
    for (genvar i = 0; i < `SORT_LANES; i++)
    begin : g_row
        for (genvar j = i + 1; j < `SORT_LANES; j++)
        begin : g_col
            a_one_of_pair : assert property (
                @(posedge clk) disable iff (rst)
                cmp_valid |-> (cmp_prec[i][j] ^ cmp_prec[j][i])
            );
        end
    end

endmodule

/* src/rank_counter.sv */
`timescale 1ns/100ps
`include "sort_defs.svh"

module rank_counter
    import sort_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmp_valid,
    input  key_vec_t  cmp_keys,
    input  prec_mat_t cmp_prec,
    output logic      rank_valid,
    output key_vec_t  rank_keys,
    output idx_vec_t  ranks
);

    idx_vec_t rank_next;

    // Population count of one row
    // Diagonal is never set, so the count fits in idx_t
    function automatic idx_t count_row(input logic [`SORT_LANES-1:0] row);
        idx_t total;
        total = '0;
        for (int j = 0; j < `SORT_LANES; j++)
        begin
            total = total + idx_t'(row[j]);
        end
        return total;
    endfunction

    //////////////////////////////
    // Rank per lane
    //////////////////////////////

    always_comb
    begin
        for (int i = 0; i < `SORT_LANES; i++)
        begin
            rank_next[i] = count_row(cmp_prec[i]);
        end
    end

    //////////////////////////////
    // Stage registers
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rank_valid <= 1'b0;
        end
        else
        begin
            rank_valid <= cmp_valid;
        end
    end

    // Keys follow their ranks into the scatter stage
    always_ff @(posedge clk)
    begin
        rank_keys <= cmp_keys;
        ranks     <= rank_next;
    end

endmodule

/* src/rank_scatter.sv */
`timescale 1ns/100ps
`include "sort_defs.svh"

module rank_scatter
    import sort_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     rank_valid,
    input  key_vec_t rank_keys,
    input  idx_vec_t ranks,
    output logic     out_valid,
    output key_vec_t out_keys,
    output idx_vec_t out_index
);

    // Row s, bit l set when lane l has rank s
    logic [`SORT_LANES-1:0][`SORT_LANES-1:0] claim;
    key_vec_t slot_keys;
    idx_vec_t slot_index;

    //////////////////////////////
    // Slot claims
    //////////////////////////////

    always_comb
    begin
        for (int s = 0; s < `SORT_LANES; s++)
        begin
            for (int l = 0; l < `SORT_LANES; l++)
            begin
                claim[s][l] = (ranks[l] == idx_t'(s));
            end
        end
    end

    //////////////////////////////
    // Slot select
    //////////////////////////////

    // One lane per slot when ranks are a permutation
    always_comb
    begin
        for (int s = 0; s < `SORT_LANES; s++)
        begin
            slot_keys[s]  = '0;
            slot_index[s] = '0;
            for (int l = 0; l < `SORT_LANES; l++)
            begin
                if (claim[s][l])
                begin
                    slot_keys[s]  = rank_keys[l];
                    slot_index[s] = idx_t'(l);
                end
            end
        end
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= rank_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        out_keys  <= slot_keys;
        out_index <= slot_index;
    end

    // Ranks from the counter must cover every slot exactly once
    for (genvar s = 0; s < `SORT_LANES; s++)
    begin : g_slot
        a_slot_claimed_once : assert property (
            @(posedge clk) disable iff (rst)
            rank_valid |-> $onehot(claim[s])
        );
    end

endmodule

/* src/parallel_sort.sv */
`timescale 1ns/100ps

module parallel_sort
    import sort_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  key_vec_t in_keys,
    output logic     out_valid,
    output key_vec_t out_keys,
    output idx_vec_t out_index
);

    // Compare to rank
    logic      cmp_valid;
    key_vec_t  cmp_keys;
    prec_mat_t cmp_prec;

    // Rank to scatter
    logic      rank_valid;
    key_vec_t  rank_keys;
    idx_vec_t  ranks;

    compare_matrix compare_matrix_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_keys   (in_keys),
        .cmp_valid (cmp_valid),
        .cmp_keys  (cmp_keys),
        .cmp_prec  (cmp_prec)
    );

    rank_counter rank_counter_inst (
        .clk        (clk),
        .rst        (rst),
        .cmp_valid  (cmp_valid),
        .cmp_keys   (cmp_keys),
        .cmp_prec   (cmp_prec),
        .rank_valid (rank_valid),
        .rank_keys  (rank_keys),
        .ranks      (ranks)
    );

    rank_scatter rank_scatter_inst (
        .clk        (clk),
        .rst        (rst),
        .rank_valid (rank_valid),
        .rank_keys  (rank_keys),
        .ranks      (ranks),
        .out_valid  (out_valid),
        .out_keys   (out_keys),
        .out_index  (out_index)
    );

endmodule

/* testbench/sort_ref.svh */
`ifndef SORT_REF_SVH
`define SORT_REF_SVH

`include "sort_defs.svh"

//////////////////////////////
// Reference model
//////////////////////////////

// Stable ascending sort by insertion, lane order kept for equal keys
function automatic void ref_sort(
    input  key_vec_t keys,
    output key_vec_t sorted,
    output idx_vec_t index
);
    key_t cur_key;
    idx_t cur_idx;
    int   pos;
    for (int i = 0; i < `SORT_LANES; i++)
    begin
        sorted[i] = keys[i];
        index[i]  = idx_t'(i);
    end
    for (int i = 1; i < `SORT_LANES; i++)
    begin
        cur_key = sorted[i];
        cur_idx = index[i];
        pos     = i;
        // Strict compare, so an earlier lane stays ahead on a tie
        while ((pos > 0) && (sorted[pos-1] > cur_key))
        begin
            sorted[pos] = sorted[pos-1];
            index[pos]  = index[pos-1];
            pos--;
        end
        sorted[pos] = cur_key;
        index[pos]  = cur_idx;
    end
endfunction

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_keys(
    input key_vec_t expected,
    input key_vec_t actual,
    input int       set_no
);
    for (int s = 0; s < `SORT_LANES; s++)
    begin
        if (actual[s] !== expected[s])
        begin
            fail_run($sformatf("ERROR out_keys[%0d] set %0d expected 0x%h actual 0x%h",
                               s, set_no, expected[s], actual[s]));
        end
    end
endtask

task automatic check_index(
    input idx_vec_t expected,
    input idx_vec_t actual,
    input int       set_no
);
    for (int s = 0; s < `SORT_LANES; s++)
    begin
        if (actual[s] !== expected[s])
        begin
            fail_run($sformatf("ERROR out_index[%0d] set %0d expected 0x%h actual 0x%h",
                               s, set_no, expected[s], actual[s]));
        end
    end
endtask

`endif

/* testbench/tb_parallel_sort.sv */
`timescale 1ns/100ps
`include "sort_defs.svh"

module tb_parallel_sort
    import sort_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_START   = 6;
    localparam int N_RANDOM     = 200;
    localparam int N_DUP        = 6;
    // Three uniform sets, the duplicate sets and one descending set
    localparam int N_DIRECTED   = N_DUP + 4;
    localparam int N_GAPPED     = 100;
    localparam int MAX_GAP      = 3;
    localparam int DRAIN_CYCLES = 8;

    localparam int N_SETS          = N_RANDOM + N_DIRECTED + N_GAPPED;
    localparam int GAP_CYCLES      = IDLE_START + N_GAPPED * MAX_GAP + DRAIN_CYCLES;
    localparam int WATCHDOG_CYCLES = N_SETS + GAP_CYCLES + RESET_CYCLES + 20;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    key_vec_t in_keys;
    logic     out_valid;
    key_vec_t out_keys;
    idx_vec_t out_index;

    key_vec_t   exp_keys_q[$];
    idx_vec_t   exp_index_q[$];
    int         sets_sent    = 0;
    int         sets_checked = 0;
    integer     seed         = 56184;
    logic [2:0] valid_hist   = '0;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "Stopped at first failure");
    endtask

    `include "sort_ref.svh"

    parallel_sort parallel_sort_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_keys   (in_keys),
        .out_valid (out_valid),
        .out_keys  (out_keys),
        .out_index (out_index)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic key_vec_t random_keys();
        key_vec_t keys;
        for (int i = 0; i < `SORT_LANES; i++)
        begin
            keys[i] = key_t'($random(seed));
        end
        return keys;
    endfunction

    // Only four distinct values, so most keys repeat
    function automatic key_vec_t duplicate_keys();
        key_vec_t keys;
        for (int i = 0; i < `SORT_LANES; i++)
        begin
            keys[i] = key_t'(8'h40) + key_t'($random(seed) & 3);
        end
        return keys;
    endfunction

    function automatic key_vec_t uniform_keys(input key_t value);
        key_vec_t keys;
        for (int i = 0; i < `SORT_LANES; i++)
        begin
            keys[i] = value;
        end
        return keys;
    endfunction

    // 0xFF in lane 0 down to 0x00 in lane 15
    function automatic key_vec_t descending_keys();
        key_vec_t keys;
        for (int i = 0; i < `SORT_LANES; i++)
        begin
            keys[i] = key_t'(8'hFF - 17 * i);
        end
        return keys;
    endfunction

    task automatic drive_set(input key_vec_t keys);
        key_vec_t sorted;
        idx_vec_t index;
        @(negedge clk);
        in_valid = 1'b1;
        in_keys  = keys;
        ref_sort(keys, sorted, index);
        exp_keys_q.push_back(sorted);
        exp_index_q.push_back(index);
        sets_sent++;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_keys  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Nothing may come out before the first set
        repeat (IDLE_START)
        begin
            @(negedge clk);
            if (out_valid !== 1'b0)
            begin
                fail_run("out_valid was not low after reset with no set sent");
            end
        end

        // Back to back random sets
        for (int n = 0; n < N_RANDOM; n++)
        begin
            drive_set(random_keys());
        end

        // Ties and ordering corners
        drive_set(uniform_keys(8'h5A));
        drive_set(uniform_keys(8'h00));
        drive_set(uniform_keys(8'hFF));
        for (int n = 0; n < N_DUP; n++)
        begin
            drive_set(duplicate_keys());
        end
        drive_set(descending_keys());

        // Random gaps between sets
        for (int n = 0; n < N_GAPPED; n++)
        begin
            drive_set(random_keys());
            drive_idle($random(seed) & MAX_GAP);
        end

        drive_idle(DRAIN_CYCLES);

        if (exp_keys_q.size() != 0)
        begin
            fail_run($sformatf("%0d sets were sent but never came out", exp_keys_q.size()));
        end
        else
        begin
            $display("Verification passed");
            $finish;
        end
    end

    //////////////////////////////
    // Output compare
    //////////////////////////////

    always @(posedge clk)
    begin
        key_vec_t exp_keys;
        idx_vec_t exp_index;
        if (!rst)
        begin
            // Value seen here was registered on the previous edge, three edges after in_valid
            if (out_valid !== valid_hist[2])
            begin
                fail_run($sformatf(
                    "out_valid was %b at %0t but in_valid three cycles earlier was %b",
                    out_valid, $time, valid_hist[2]));
            end
            if (out_valid === 1'b1)
            begin
                if (exp_keys_q.size() == 0)
                begin
                    fail_run("out_valid went high with no set waiting for a result");
                end
                else
                begin
                    exp_keys  = exp_keys_q.pop_front();
                    exp_index = exp_index_q.pop_front();
                    check_keys(exp_keys, out_keys, sets_checked);
                    check_index(exp_index, out_index, sets_checked);
                    sets_checked++;
                end
            end
        end
        valid_hist <= {valid_hist[1:0], in_valid & ~rst};
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("Timeout after %0d cycles, %0d of %0d sets checked",
                           WATCHDOG_CYCLES, sets_checked, sets_sent));
    end

endmodule

/* vlog.f */
+incdir+src
+incdir+testbench
src/sort_pkg.sv
src/compare_matrix.sv
src/rank_counter.sv
src/rank_scatter.sv
src/parallel_sort.sv
testbench/tb_parallel_sort.sv

/* Bender.yml */
package:
  name: parallel_sort

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/sort_pkg.sv
      - src/compare_matrix.sv
      - src/rank_counter.sv
      - src/rank_scatter.sv
      - src/parallel_sort.sv

  - target: test
    include_dirs:
      - src
      - testbench
    files:
      - testbench/tb_parallel_sort.sv
